// ==== include/fir_coeffs.svh ====
// symmetric low-pass taps, entry k weighs the sample from k strobes ago
// the taps sum to 1024
localparam logic signed [fir_pkg::COEFF_WIDTH-1:0] FIR_COEFFS [fir_pkg::NUM_TAPS] = '{
    -1,
    -2,
    -3,
    -5,
    -6,
    -5,
    0,
    10,
    25,
    45,
    67,
    90,
    110,
    123,
    128,   // center tap
    123,
    110,
    90,
    67,
    45,
    25,
    10,
    0,
    -5,
    -6,
    -5,
    -3,
    -2,
    -1,
    0,     // last three are padding
    0,
    0
};

// ==== hdl/fir_pkg.sv ====
package fir_pkg;

    // filter geometry, tied to the table in fir_coeffs.svh
    localparam int NUM_TAPS      = 32;
    localparam int TAP_IDX_WIDTH = 5;   // enough to index NUM_TAPS entries

    // coefficient format
    localparam int COEFF_WIDTH = 16;    // signed

    // taps sum to 1 << COEFF_SHIFT, so the shift restores unity dc gain
    localparam int COEFF_SHIFT = 10;

    // sequencer phases for one sample
    //   IDLE  waiting for a strobe
    //   MAC   one multiply-accumulate per cycle, tap 0 first
    //   ROUND round, shift, saturate and load the output register
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        MAC   = 2'd1,
        ROUND = 2'd2
    } fir_state_t;

endpackage

// ==== hdl/tap_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tap_counter import fir_pkg::*; (
    input  wire                      clk_in,
    input  wire                      rst_in,
    input  wire                      clear,
    input  wire                      advance,
    output logic [TAP_IDX_WIDTH-1:0] tap_index,
    output logic                     last_tap
);

    localparam logic [TAP_IDX_WIDTH-1:0] LAST_IDX = TAP_IDX_WIDTH'(NUM_TAPS - 1);

    assign last_tap = advance && (tap_index == LAST_IDX);

    always_ff @(posedge clk_in) begin
        if (rst_in || clear) begin
            tap_index <= '0;
        end else if (advance && !last_tap) begin
            tap_index <= tap_index + 1'b1;
        end   // holds at the last tap until the next clear
    end

    // the sequencer has to leave MAC right after the last tap
    a_stop_after_last: assert property (
        @(posedge clk_in) disable iff (rst_in)
        (advance && tap_index == LAST_IDX) |=> !advance
    ) else $error("tap_counter: advance past last tap");

endmodule

`default_nettype wire

// ==== hdl/fir_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fir_sequencer import fir_pkg::*; (
    input  wire  clk_in,
    input  wire  rst_in,
    input  wire  valid_in,
    input  wire  last_tap,
    output logic shift_en,
    output logic acc_clear,
    output logic mac_en,
    output logic out_load,
    output logic busy
);

    fir_state_t state;
    fir_state_t state_next;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            IDLE:    if (valid_in) state_next = MAC;
            MAC:     if (last_tap) state_next = ROUND;
            ROUND:   state_next = IDLE;   // output loads on this edge
            default: state_next = IDLE;
        endcase
    end

    // a strobe only takes effect in IDLE, anything else is dropped
    assign shift_en  = (state == IDLE) && valid_in;
    assign acc_clear = (state == IDLE) && valid_in;
    assign mac_en    = (state == MAC);
    assign out_load  = (state == ROUND);
    assign busy      = (state != IDLE);

    // one mac cycle per tap, then straight into the round cycle
    a_mac_length: assert property (
        @(posedge clk_in) disable iff (rst_in)
        out_load |-> $past(mac_en, NUM_TAPS) && !$past(mac_en, NUM_TAPS + 1)
    ) else $error("fir_sequencer: mac phase did not last one cycle per tap");

endmodule

`default_nettype wire

// ==== hdl/sample_delay_line.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_delay_line import fir_pkg::*; #(
    parameter int DATA_WIDTH = 8
) (
    input  wire                          clk_in,
    input  wire                          rst_in,
    input  wire                          shift_en,
    input  wire signed [DATA_WIDTH-1:0]  sample_in,
    input  wire        [TAP_IDX_WIDTH-1:0] tap_index,
    output logic signed [DATA_WIDTH-1:0] tap_sample
);

    logic signed [DATA_WIDTH-1:0] line [NUM_TAPS];   // line[k] is k strobes old

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                line[i] <= '0;
            end
        end else if (shift_en) begin
            line[0] <= sample_in;
            for (int i = 1; i < NUM_TAPS; i++) begin
                line[i] <= line[i-1];
            end
        end
    end

    // read port for the mac loop
    assign tap_sample = line[tap_index];

endmodule

`default_nettype wire

// ==== hdl/mac_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_datapath import fir_pkg::*; #(
    parameter int DATA_WIDTH = 8
) (
    input  wire                            clk_in,
    input  wire                            rst_in,
    input  wire                            acc_clear,
    input  wire                            mac_en,
    input  wire                            out_load,
    input  wire        [TAP_IDX_WIDTH-1:0] tap_index,
    input  wire signed [DATA_WIDTH-1:0]    tap_sample,
    output logic signed [DATA_WIDTH-1:0]   filtered_audio,
    output logic                           data_ready
);

    `include "fir_coeffs.svh"

    localparam int PROD_WIDTH = DATA_WIDTH + COEFF_WIDTH;
    localparam int ACC_WIDTH  = DATA_WIDTH + COEFF_WIDTH + TAP_IDX_WIDTH;   // room for 32 sums

    // half an output step, one at bit COEFF_SHIFT-1
    localparam logic signed [ACC_WIDTH-1:0] ROUND_CONST = ACC_WIDTH'(1) <<< (COEFF_SHIFT - 1);
    localparam logic signed [ACC_WIDTH-1:0] OUT_MAX = (ACC_WIDTH'(1) <<< (DATA_WIDTH - 1)) - 1;
    localparam logic signed [ACC_WIDTH-1:0] OUT_MIN = -(ACC_WIDTH'(1) <<< (DATA_WIDTH - 1));

    logic signed [COEFF_WIDTH-1:0] coeff;
    logic signed [PROD_WIDTH-1:0]  product;
    logic signed [ACC_WIDTH-1:0]   product_ext;
    logic signed [ACC_WIDTH-1:0]   acc;
    logic signed [ACC_WIDTH-1:0]   acc_rounded;
    logic signed [ACC_WIDTH-1:0]   acc_shifted;
    logic signed [DATA_WIDTH-1:0]  sat_value;

    assign coeff       = FIR_COEFFS[tap_index];
    assign product     = PROD_WIDTH'(tap_sample) * PROD_WIDTH'(coeff);
    assign product_ext = ACC_WIDTH'(product);   // sign extends to the accumulator width

    always_ff @(posedge clk_in) begin
        if (acc_clear) begin
            acc <= '0;
        end else if (mac_en) begin
            acc <= acc + product_ext;
        end
    end

    // round half up, then drop the coefficient scale
    assign acc_rounded = acc + ROUND_CONST;
    assign acc_shifted = acc_rounded >>> COEFF_SHIFT;

    always_comb begin
        if (acc_shifted > OUT_MAX) begin
            sat_value = OUT_MAX[DATA_WIDTH-1:0];
        end else if (acc_shifted < OUT_MIN) begin
            sat_value = OUT_MIN[DATA_WIDTH-1:0];
        end else begin
            sat_value = acc_shifted[DATA_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            filtered_audio <= '0;
            data_ready     <= 1'b0;
        end else begin
            data_ready <= out_load;   // pulse in the cycle after the load
            if (out_load) begin
                filtered_audio <= sat_value;
            end
        end
    end

    // out_load is a single ROUND cycle, so ready can never stretch
    a_ready_single: assert property (
        @(posedge clk_in) disable iff (rst_in)
        data_ready |=> !data_ready
    ) else $error("mac_datapath: data_ready high two cycles in a row");

endmodule

`default_nettype wire

// ==== hdl/audio_fir_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module audio_fir_top import fir_pkg::*; #(
    parameter int DATA_WIDTH = 8
) (
    input  wire                          clk_in,
    input  wire                          rst_in,
    input  wire signed [DATA_WIDTH-1:0]  audio_in,
    input  wire                          valid_in,
    output logic signed [DATA_WIDTH-1:0] filtered_audio,
    output logic                         data_ready,
    output logic                         busy
);

    logic                         shift_en;
    logic                         acc_clear;
    logic                         mac_en;
    logic                         out_load;
    logic                         last_tap;
    logic [TAP_IDX_WIDTH-1:0]     tap_index;
    logic signed [DATA_WIDTH-1:0] tap_sample;

    fir_sequencer u_sequencer (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .valid_in  (valid_in),
        .last_tap  (last_tap),
        .shift_en  (shift_en),
        .acc_clear (acc_clear),
        .mac_en    (mac_en),
        .out_load  (out_load),
        .busy      (busy)
    );

    // counter restarts with the accumulator, steps with each mac
    tap_counter u_tap_counter (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .clear     (acc_clear),
        .advance   (mac_en),
        .tap_index (tap_index),
        .last_tap  (last_tap)
    );

    sample_delay_line #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_delay_line (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .shift_en   (shift_en),
        .sample_in  (audio_in),
        .tap_index  (tap_index),
        .tap_sample (tap_sample)
    );

    mac_datapath #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_datapath (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .acc_clear      (acc_clear),
        .mac_en         (mac_en),
        .out_load       (out_load),
        .tap_index      (tap_index),
        .tap_sample     (tap_sample),
        .filtered_audio (filtered_audio),
        .data_ready     (data_ready)
    );

endmodule

`default_nettype wire

// ==== verification/audio_fir_tb.sv ====
`timescale 1ns/1ps

module audio_fir_tb import fir_pkg::*; ();

    localparam int DATA_WIDTH    = 8;
    localparam int CLK_PERIOD    = 40;
    localparam int LATENCY       = 33;   // accepted strobe to data_ready, in cycles
    localparam int READY_TIMEOUT = 40;
    localparam int HALF_STEP     = 512;
    localparam int OUT_SHIFT     = 10;
    localparam int OUT_MAX       = 127;
    localparam int OUT_MIN       = -128;
    localparam int TOTAL_SAMPLES = 1 + 32 + 80 + 64 + 200 + 20;
    localparam longint WATCHDOG_NS = longint'(TOTAL_SAMPLES) * 40 * CLK_PERIOD * 2;

    `include "fir_coeffs.svh"

    logic                         clk_in;
    logic                         rst_in;
    logic signed [DATA_WIDTH-1:0] audio_in;
    logic                         valid_in;
    logic signed [DATA_WIDTH-1:0] filtered_audio;
    logic                         data_ready;
    logic                         busy;

    logic                         accepted;
    logic                         ready_seen;
    logic signed [DATA_WIDTH-1:0] history [NUM_TAPS];   // accepted samples, newest at 0
    logic signed [DATA_WIDTH-1:0] expected_q [$];
    logic signed [DATA_WIDTH-1:0] expected_head;
    int                           error_count;
    int                           tests_run;
    int                           tests_failed;

    audio_fir_top #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_dut (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .audio_in       (audio_in),
        .valid_in       (valid_in),
        .filtered_audio (filtered_audio),
        .data_ready     (data_ready),
        .busy           (busy)
    );

    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    assign accepted = valid_in && !busy;   // strobes during busy are dropped

    // sum of products, round half up, shift, clamp
    function automatic logic signed [DATA_WIDTH-1:0] reference_output();
        int sum;
        int scaled;
        sum = 0;
        for (int k = 0; k < NUM_TAPS; k++) begin
            sum += int'(FIR_COEFFS[k]) * int'(history[k]);
        end
        scaled = (sum + HALF_STEP) >>> OUT_SHIFT;
        if (scaled > OUT_MAX) begin
            scaled = OUT_MAX;
        end else if (scaled < OUT_MIN) begin
            scaled = OUT_MIN;
        end
        return DATA_WIDTH'(scaled);
    endfunction

    always @(posedge clk_in) begin
        ready_seen = data_ready;
        if (rst_in) begin
            for (int k = 0; k < NUM_TAPS; k++) begin
                history[k] = '0;
            end
            expected_q.delete();
        end else if (accepted) begin
            for (int k = NUM_TAPS - 1; k > 0; k--) begin
                history[k] = history[k-1];
            end
            history[0] = audio_in;
            expected_q.push_back(reference_output());
        end
    end

    // head moves only on the falling edge, so it is stable at every check
    always @(negedge clk_in) begin
        if (ready_seen === 1'b1 && expected_q.size() > 0) begin
            void'(expected_q.pop_front());
        end
        if (expected_q.size() > 0) begin
            expected_head = expected_q[0];
        end
    end

    // ready is registered on the 33rd edge and seen on the next one
    a_ready_latency: assert property (
        @(posedge clk_in) disable iff (rst_in)
        data_ready == $past(accepted, LATENCY + 1)
    ) else begin
        $display("error at %0t: data_ready does not follow an accepted strobe by %0d cycles",
                 $time, LATENCY);
        error_count++;
    end

    a_output_value: assert property (
        @(posedge clk_in) disable iff (rst_in)
        data_ready |-> (filtered_audio == expected_head)
    ) else begin
        $display("mismatch at %0t: filtered_audio = %0d, expected %0d",
                 $time, filtered_audio, expected_head);
        error_count++;
    end

    // busy rises right after the accepting edge and falls with the output load
    a_busy_window: assert property (
        @(posedge clk_in) disable iff (rst_in)
        $changed(busy) |-> (busy ? $past(accepted) : $past(accepted, LATENCY + 1))
    ) else begin
        $display("error at %0t: busy changed without a matching accepted strobe", $time);
        error_count++;
    end

    task automatic check_value(input string signal_name, input int actual, input int expected);
        assert (actual == expected) else begin
            $display("mismatch at %0t: %s = %0d, expected %0d",
                     $time, signal_name, actual, expected);
            error_count++;
        end
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (data_ready !== 1'b1 && cycles < READY_TIMEOUT) begin
            @(posedge clk_in);
            cycles++;
        end
        if (data_ready !== 1'b1) begin
            $display("error at %0t: no data_ready within %0d cycles of a strobe",
                     $time, READY_TIMEOUT);
            error_count++;
        end
    endtask

    task automatic send_sample(input logic signed [DATA_WIDTH-1:0] value);
        @(posedge clk_in);
        audio_in <= value;
        valid_in <= 1'b1;
        @(posedge clk_in);
        valid_in <= 1'b0;
        wait_ready();
    endtask

    // one accepted strobe, then three more while the engine is busy
    task automatic send_with_drops(input logic signed [DATA_WIDTH-1:0] value);
        int gap;
        @(posedge clk_in);
        audio_in <= value;
        valid_in <= 1'b1;
        @(posedge clk_in);
        valid_in <= 1'b0;
        repeat (3) begin
            gap = $urandom_range(1, 8);
            repeat (gap) @(posedge clk_in);
            audio_in <= DATA_WIDTH'($urandom);
            valid_in <= 1'b1;
            @(posedge clk_in);
            valid_in <= 1'b0;
        end
        wait_ready();
    endtask

    task automatic finish_test(input string name, input int errors_before);
        @(negedge clk_in);   // let the last concurrent check report first
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t, the run did not finish", $time);
        $display("tests failed");
        $finish;
    end

    initial begin
        int errors_before;
        int gap;
        void'($urandom(32'h64d6));
        clk_in      = 1'b0;
        rst_in      = 1'b1;
        audio_in    = '0;
        valid_in    = 1'b0;
        error_count = 0;
        repeat (2) @(posedge clk_in);
        rst_in <= 1'b0;
        @(posedge clk_in);

        errors_before = error_count;
        check_value("data_ready", data_ready, 0);
        check_value("busy", busy, 0);
        check_value("filtered_audio", filtered_audio, 0);
        send_sample(0);
        check_value("filtered_audio", filtered_audio, 0);
        finish_test("reset state", errors_before);

        errors_before = error_count;
        send_sample(100);
        repeat (NUM_TAPS - 1) send_sample(0);
        finish_test("impulse response", errors_before);

        errors_before = error_count;
        repeat (40) send_sample(57);
        check_value("filtered_audio", filtered_audio, 57);   // unity dc gain
        repeat (40) send_sample(DATA_WIDTH'(OUT_MIN));
        check_value("filtered_audio", filtered_audio, OUT_MIN);
        finish_test("dc step", errors_before);

        errors_before = error_count;
        for (int k = NUM_TAPS - 1; k >= 0; k--) begin
            send_sample(DATA_WIDTH'((FIR_COEFFS[k] >= 0) ? OUT_MAX : OUT_MIN));
        end
        check_value("filtered_audio", filtered_audio, OUT_MAX);
        for (int k = NUM_TAPS - 1; k >= 0; k--) begin
            send_sample(DATA_WIDTH'((FIR_COEFFS[k] >= 0) ? OUT_MIN : OUT_MAX));
        end
        check_value("filtered_audio", filtered_audio, OUT_MIN);
        finish_test("saturation", errors_before);

        errors_before = error_count;
        repeat (200) begin
            send_sample(DATA_WIDTH'($urandom_range(0, 255)));
            gap = $urandom_range(0, 5);
            repeat (gap) @(posedge clk_in);
        end
        finish_test("random stream", errors_before);

        errors_before = error_count;
        repeat (20) send_with_drops(DATA_WIDTH'($urandom));
        finish_test("dropped samples", errors_before);

        $display("%0d tests run, %0d failing, %0d errors", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== audio_fir_top.f ====
+incdir+include
hdl/fir_pkg.sv
hdl/tap_counter.sv
hdl/fir_sequencer.sv
hdl/sample_delay_line.sv
hdl/mac_datapath.sv
hdl/audio_fir_top.sv
verification/audio_fir_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TB_TOP     ?= audio_fir_tb
RTL_TOP    ?= audio_fir_top
FILELIST   ?= audio_fir_top.f
BUILD_DIR  ?= obj_dir
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   ?= all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only if the pass message shows up in the output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
